//--- sim.f
+incdir+source
source/lenet_pkg.sv
source/window_iterator.sv
source/conv_engine.sv
source/feature_buffer.sv
source/pool_relu.sv
source/dense_argmax.sv
source/lenet_top.sv
testbench/tb_lenet.sv

//--- source/conv_engine.sv
// ##########################################################
// convolution engine
// two-plane 3x3 multiply-accumulate on the image stream,
// scaled and saturated to one feature word per window
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "lenet_macros.svh"

module conv_engine import lenet_pkg::*; (
	input  wire logic         clk,
	input  wire logic         reset_i,
	input  wire window_ctrl_t ctrl_i,
	input  wire pixel_t       data_i,
	output logic              wr_en_o,
	output feature_word_t     word_o
);

	localparam int TAPS = `LENET_CONV_K * `LENET_CONV_K;
	localparam acc_t FEAT_MAX = acc_t'(2 ** (`LENET_PIX_W - 1) - 1);
	localparam acc_t FEAT_MIN = -FEAT_MAX - acc_t'(1);

	// low byte plane 0, high byte plane 1
	logic [2*`LENET_PIX_W-1:0] weight_rom [TAPS];

	window_ctrl_t ctrl_d;
	logic [$clog2(TAPS)-1:0] tap;
	pixel_t w0;
	pixel_t w1;
	acc_t acc0;
	acc_t acc1;
	acc_t prod0;
	acc_t prod1;
	acc_t sum0;
	acc_t sum1;

	initial begin
		$readmemh("source/conv_weights.hex", weight_rom);
	end

	function automatic feature_t saturate(input acc_t value);
		acc_t shifted;
		shifted = value >>> `LENET_WEIGHT_SHIFT;
		if (shifted > FEAT_MAX)
			return feature_t'(FEAT_MAX);
		else if (shifted < FEAT_MIN)
			return feature_t'(FEAT_MIN);
		return feature_t'(shifted);
	endfunction

	assign w0 = pixel_t'(weight_rom[tap][`LENET_PIX_W-1:0]);
	assign w1 = pixel_t'(weight_rom[tap][2*`LENET_PIX_W-1:`LENET_PIX_W]);

	assign prod0 = data_i * w0;
	assign prod1 = data_i * w1;

	// first tap starts a fresh sum
	assign sum0 = (ctrl_d.first ? acc_t'(0) : acc0) + prod0;
	assign sum1 = (ctrl_d.first ? acc_t'(0) : acc1) + prod1;

	// control lines up with the pixel that returns a cycle later
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctrl_d  <= '0;
			tap     <= '0;
			wr_en_o <= 1'b0;
		end else begin
			ctrl_d  <= ctrl_i;
			wr_en_o <= ctrl_d.valid & ctrl_d.last;
			if (ctrl_d.valid)
				tap <= ctrl_d.last ? '0 : tap + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_d.valid) begin
			acc0 <= sum0;
			acc1 <= sum1;
		end
		if (ctrl_d.valid && ctrl_d.last) begin
			word_o.plane0 <= saturate(sum0);
			word_o.plane1 <= saturate(sum1);
		end
	end

endmodule

`default_nettype wire

//--- source/conv_weights.hex
// one word per kernel tap, tap index ky*3+kx
// upper byte plane 1 weight, lower byte plane 0 weight
F60C
0508
0EFA
F910
0B14
09F3
EE04
06F8
0D0A

//--- source/dense_argmax.sv
// ##########################################################
// dense layer and argmax
// accumulates ten class scores over the pooled words and
// reports the lowest index holding the top score
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "lenet_macros.svh"

module dense_argmax import lenet_pkg::*; (
	input  wire logic          clk,
	input  wire logic          reset_i,
	input  wire logic          start_i,
	input  wire logic          valid_i,
	input  wire feature_word_t word_i,
	output digit_t             digit_o,
	output logic               ready_o
);

	localparam int POSITIONS = `LENET_POOL_MAP * `LENET_POOL_MAP;
	localparam int ROW_W = `LENET_PLANES * `LENET_CLASSES * `LENET_PIX_W;
	localparam int POS_W = $clog2(POSITIONS);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(POSITIONS - 1);

	// one row per pooled position, leftmost byte is plane 0 class 0
	logic [ROW_W-1:0] fc_rom [POSITIONS];

	logic [POS_W-1:0] pos;
	score_t scores [`LENET_CLASSES];
	logic scan_q;
	digit_t best;

	initial begin
		$readmemh("source/fc_weights.hex", fc_rom);
	end

	function automatic pixel_t fc_weight(input logic [ROW_W-1:0] row, input int idx);
		return pixel_t'(row[ROW_W - 1 - idx * `LENET_PIX_W -: `LENET_PIX_W]);
	endfunction

	// strict compare keeps the lowest index on ties
	always_comb begin
		best = '0;
		for (int c = 1; c < `LENET_CLASSES; c++) begin
			if (scores[c] > scores[best])
				best = digit_t'(c);
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			for (int c = 0; c < `LENET_CLASSES; c++)
				scores[c] <= '0;
		end else if (valid_i) begin
			for (int c = 0; c < `LENET_CLASSES; c++)
				scores[c] <= scores[c]
					+ word_i.plane0 * fc_weight(fc_rom[pos], c)
					+ word_i.plane1 * fc_weight(fc_rom[pos], c + `LENET_CLASSES);
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pos     <= '0;
			scan_q  <= 1'b0;
			ready_o <= 1'b0;
			digit_o <= '0;
		end else begin
			scan_q  <= 1'b0;
			ready_o <= scan_q;
			if (start_i) begin
				pos <= '0;
			end else if (valid_i) begin
				if (pos == LAST_POS) begin
					pos    <= '0;
					scan_q <= 1'b1;
				end else begin
					pos <= pos + 1'b1;
				end
			end
			// result held until the next image completes
			if (scan_q)
				digit_o <= best;
		end
	end

endmodule

`default_nettype wire

//--- source/fc_weights.hex
// one row per pooled position py*3+px
// bytes left to right: plane 0 classes 0 to 9, then plane 1 classes 0 to 9
0CF4071AE90311F008FD050EF80213EA09F6040B
F2091506FB0E0AEC11030DF6120708F1FA0E0315
0612F90BF1050D07EE10F30A05160C04F80AFC11
150308EF0A12F4060D020804130BF2FE100709F5
FB0C11F40716EA03050E09F1040D12F806FA1402
07ED0A03F60F1208FC0B1005F30C0209EE1107F7
0E02F81509FB0410EF06F41308010B06F90D12EC
03110CF71408F2050A0F0AF81605F31207E90C04
1106F5090DEE0B1302F8050C03F008150E04F610

//--- source/feature_buffer.sv
// ##########################################################
// feature buffer
// dual-port store of conv words kept in arrival order
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "lenet_macros.svh"

module feature_buffer import lenet_pkg::*; (
	input  wire logic          clk,
	input  wire logic          reset_i,
	input  wire logic          wr_en_i,
	input  wire feature_word_t wr_data_i,
	input  wire logic          rd_en_i,
	input  wire buf_addr_t     rd_addr_i,
	output feature_word_t      rd_data_o,
	input  wire logic          restart_i
);

	localparam int DEPTH = `LENET_CONV_MAP * `LENET_CONV_MAP;

	feature_word_t mem [DEPTH];
	buf_addr_t wr_ptr;

	// write pointer rewinds at the start of every image
	always_ff @(posedge clk) begin
		if (reset_i)
			wr_ptr <= '0;
		else if (restart_i)
			wr_ptr <= '0;
		else if (wr_en_i)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_ptr] <= wr_data_i;
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

//--- source/lenet_macros.svh
// ##########################################################
// lenet parameters
// sizes, widths and scaling of the cut-down classifier
// ##########################################################

`ifndef LENET_MACROS_SVH
`define LENET_MACROS_SVH

// image and layer geometry
`define LENET_IMG_SIZE      8
`define LENET_CONV_K        3
`define LENET_CONV_MAP      6
`define LENET_POOL_MAP      3
`define LENET_PLANES        2
`define LENET_CLASSES       10

// datapath widths
`define LENET_PIX_W         8
`define LENET_ACC_W         20

// conv sums are scaled down by this many bits before saturation
`define LENET_WEIGHT_SHIFT  6

// address widths
`define LENET_SRC_AW        6
`define LENET_BUF_AW        6

`endif

//--- source/lenet_pkg.sv
// ##########################################################
// lenet types
// data, address and window control types of the classifier
// ##########################################################

`default_nettype none

`include "lenet_macros.svh"

package lenet_pkg;

	typedef logic signed [`LENET_PIX_W-1:0] pixel_t;
	typedef logic signed [`LENET_PIX_W-1:0] feature_t;
	typedef logic signed [`LENET_ACC_W-1:0] acc_t;
	typedef logic signed [23:0] score_t;

	typedef logic [`LENET_SRC_AW-1:0] src_addr_t;
	typedef logic [`LENET_BUF_AW-1:0] buf_addr_t;
	typedef logic [$clog2(`LENET_CLASSES)-1:0] digit_t;

	// one feature per plane, plane 0 in the low byte
	typedef struct packed {
		feature_t plane1;
		feature_t plane0;
	} feature_word_t;

	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} window_ctrl_t;

	typedef enum logic {ITER_IDLE, ITER_RUN} iter_state_t;

endpackage

`default_nettype wire

//--- source/lenet_top.sv
// ##########################################################
// lenet top
// conv, buffer, pooling and dense stages chained by go and
// done pulses, one image at a time
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "lenet_macros.svh"

module lenet_top import lenet_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset_i,
	input  wire logic      go_i,
	output logic           src_rd_en_o,
	output src_addr_t      src_addr_o,
	input  wire pixel_t    src_data_i,
	output digit_t         digit_o,
	output logic           ready_o
);

	logic busy;
	logic conv_go;
	logic conv_done;
	logic conv_wr_en;
	logic pool_rd_en;
	logic pool_valid;
	window_ctrl_t conv_ctrl;
	window_ctrl_t pool_ctrl;
	window_ctrl_t pool_ctrl_d;
	buf_addr_t pool_addr;
	feature_word_t conv_word;
	feature_word_t buf_rd_data;
	feature_word_t pool_word;

	// go only counts while no image is in flight
	assign conv_go = go_i & ~busy;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy        <= 1'b0;
			pool_ctrl_d <= '0;
		end else begin
			pool_ctrl_d <= pool_ctrl;
			if (conv_go)
				busy <= 1'b1;
			else if (ready_o)
				busy <= 1'b0;
		end
	end

	window_iterator #(
		.MAP_W  (`LENET_IMG_SIZE),
		.KERNEL (`LENET_CONV_K),
		.STEP   (1),
		.ADDR_W (`LENET_SRC_AW)
	) u_conv_iter (
		.clk     (clk),
		.reset_i (reset_i),
		.go_i    (conv_go),
		.rd_en_o (src_rd_en_o),
		.addr_o  (src_addr_o),
		.ctrl_o  (conv_ctrl),
		.done_o  (conv_done)
	);

	conv_engine u_conv (
		.clk     (clk),
		.reset_i (reset_i),
		.ctrl_i  (conv_ctrl),
		.data_i  (src_data_i),
		.wr_en_o (conv_wr_en),
		.word_o  (conv_word)
	);

	feature_buffer u_buf (
		.clk       (clk),
		.reset_i   (reset_i),
		.wr_en_i   (conv_wr_en),
		.wr_data_i (conv_word),
		.rd_en_i   (pool_rd_en),
		.rd_addr_i (pool_addr),
		.rd_data_o (buf_rd_data),
		.restart_i (conv_go)
	);

	// 2x2 windows with stride 2 over the conv map
	window_iterator #(
		.MAP_W  (`LENET_CONV_MAP),
		.KERNEL (2),
		.STEP   (2),
		.ADDR_W (`LENET_BUF_AW)
	) u_pool_iter (
		.clk     (clk),
		.reset_i (reset_i),
		.go_i    (conv_done),
		.rd_en_o (pool_rd_en),
		.addr_o  (pool_addr),
		.ctrl_o  (pool_ctrl),
		.done_o  ()
	);

	pool_relu u_pool (
		.clk     (clk),
		.reset_i (reset_i),
		.ctrl_i  (pool_ctrl_d),
		.data_i  (buf_rd_data),
		.valid_o (pool_valid),
		.word_o  (pool_word)
	);

	dense_argmax u_dense (
		.clk     (clk),
		.reset_i (reset_i),
		.start_i (conv_go),
		.valid_i (pool_valid),
		.word_i  (pool_word),
		.digit_o (digit_o),
		.ready_o (ready_o)
	);

endmodule

`default_nettype wire

//--- source/pool_relu.sv
// ##########################################################
// pool and relu
// 2x2 max per plane, negative maxima clipped to zero
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module pool_relu import lenet_pkg::*; (
	input  wire logic          clk,
	input  wire logic          reset_i,
	input  wire window_ctrl_t  ctrl_i,
	input  wire feature_word_t data_i,
	output logic               valid_o,
	output feature_word_t      word_o
);

	feature_t max0;
	feature_t max1;
	feature_t cur0;
	feature_t cur1;

	function automatic feature_t relu(input feature_t value);
		return (value < 0) ? feature_t'(0) : value;
	endfunction

	// running max including the current sample
	always_comb begin
		cur0 = data_i.plane0;
		cur1 = data_i.plane1;
		if (!ctrl_i.first && max0 > cur0)
			cur0 = max0;
		if (!ctrl_i.first && max1 > cur1)
			cur1 = max1;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			valid_o <= 1'b0;
		else
			valid_o <= ctrl_i.valid & ctrl_i.last;
	end

	always_ff @(posedge clk) begin
		if (ctrl_i.valid) begin
			max0 <= cur0;
			max1 <= cur1;
		end
		if (ctrl_i.valid && ctrl_i.last) begin
			word_o.plane0 <= relu(cur0);
			word_o.plane1 <= relu(cur1);
		end
	end

endmodule

`default_nettype wire

//--- source/window_iterator.sv
// ##########################################################
// window iterator
// walks kernel windows over a map in row-major order and
// issues one read address per cycle with first/last flags
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module window_iterator import lenet_pkg::*; #(
	parameter int MAP_W  = 8,
	parameter int KERNEL = 3,
	parameter int STEP   = 1,
	parameter int ADDR_W = 6
) (
	input  wire logic         clk,
	input  wire logic         reset_i,
	input  wire logic         go_i,
	output logic              rd_en_o,
	output logic [ADDR_W-1:0] addr_o,
	output window_ctrl_t      ctrl_o,
	output logic              done_o
);

	localparam int OUT_W = (MAP_W - KERNEL) / STEP + 1;
	localparam int CNT_W = $clog2(MAP_W);
	localparam logic [CNT_W-1:0] K_MAX = CNT_W'(KERNEL - 1);
	localparam logic [CNT_W-1:0] O_MAX = CNT_W'(OUT_W - 1);

	iter_state_t state;
	logic [CNT_W-1:0] kx;
	logic [CNT_W-1:0] ky;
	logic [CNT_W-1:0] ox;
	logic [CNT_W-1:0] oy;
	logic [ADDR_W-1:0] row;
	logic [ADDR_W-1:0] col;
	logic run;
	logic tap_first;
	logic tap_last;
	logic win_last;

	assign run       = (state == ITER_RUN);
	assign tap_first = (kx == '0) && (ky == '0);
	assign tap_last  = (kx == K_MAX) && (ky == K_MAX);
	assign win_last  = (ox == O_MAX) && (oy == O_MAX);

	// window origin plus kernel offset
	assign row    = ADDR_W'(oy * STEP + ky);
	assign col    = ADDR_W'(ox * STEP + kx);
	assign addr_o = ADDR_W'(row * MAP_W + col);

	assign rd_en_o      = run;
	assign ctrl_o.valid = run;
	assign ctrl_o.first = run & tap_first;
	assign ctrl_o.last  = run & tap_last;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state  <= ITER_IDLE;
			kx     <= '0;
			ky     <= '0;
			ox     <= '0;
			oy     <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				ITER_IDLE: begin
					if (go_i)
						state <= ITER_RUN;
				end
				ITER_RUN: begin
					// counters wrap to zero after the final tap
					if (kx != K_MAX) begin
						kx <= kx + 1'b1;
					end else begin
						kx <= '0;
						ky <= (ky == K_MAX) ? '0 : ky + 1'b1;
						if (ky == K_MAX) begin
							ox <= (ox == O_MAX) ? '0 : ox + 1'b1;
							if (ox == O_MAX)
								oy <= (oy == O_MAX) ? '0 : oy + 1'b1;
						end
					end
					if (tap_last && win_last) begin
						state  <= ITER_IDLE;
						done_o <= 1'b1;
					end
				end
				default: state <= ITER_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_lenet.sv
// ##########################################################
// lenet testbench
// image memory model, reference classifier and digit checks
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

`include "lenet_macros.svh"

module tb_lenet import lenet_pkg::*; ();

	localparam int IMG_PIXELS = `LENET_IMG_SIZE * `LENET_IMG_SIZE;
	localparam int CONV_WORDS = `LENET_CONV_MAP * `LENET_CONV_MAP;
	localparam int POOL_WORDS = `LENET_POOL_MAP * `LENET_POOL_MAP;
	localparam int READS_PER_IMAGE = CONV_WORDS * `LENET_CONV_K * `LENET_CONV_K;
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic reset_i;
	logic go_i;
	logic src_rd_en;
	src_addr_t src_addr;
	pixel_t src_data = '0;
	digit_t digit;
	logic ready;

	pixel_t img [IMG_PIXELS];
	logic [15:0] conv_rom_ref [`LENET_CONV_K * `LENET_CONV_K];
	logic [159:0] fc_rom_ref [POOL_WORDS];
	logic rd_pending = 1'b0;
	src_addr_t rd_addr_q = '0;

	logic [31:0] lcg_state = 32'd67471;
	digit_t exp_q [$];
	digit_t exp_digit;
	string test_name = "reset";
	int errors = 0;
	int checks = 0;
	int reads = 0;
	int ready_count = 0;
	logic ready_prev = 1'b0;
	logic aborted = 1'b0;

	lenet_top u_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.go_i        (go_i),
		.src_rd_en_o (src_rd_en),
		.src_addr_o  (src_addr),
		.src_data_i  (src_data),
		.digit_o     (digit),
		.ready_o     (ready)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// request taken at the rising edge, data driven half a cycle later
	always @(posedge clk) begin
		rd_pending <= src_rd_en;
		rd_addr_q  <= src_addr;
	end

	always @(negedge clk) begin
		if (rd_pending)
			src_data <= img[rd_addr_q];
	end

	function automatic pixel_t next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return pixel_t'(lcg_state[23:16]);
	endfunction

	function automatic int signed_byte(input logic [7:0] b);
		logic signed [7:0] s;
		s = b;
		return s;
	endfunction

	function automatic int saturate_feature(input int v);
		if (v > 127)
			return 127;
		if (v < -128)
			return -128;
		return v;
	endfunction

	function digit_t expected_digit();
		int conv0 [CONV_WORDS];
		int conv1 [CONV_WORDS];
		int pool0 [POOL_WORDS];
		int pool1 [POOL_WORDS];
		int score [`LENET_CLASSES];
		int acc0;
		int acc1;
		int pix;
		int tap;
		int base;
		int m0;
		int m1;
		int best;
		$readmemh("source/conv_weights.hex", conv_rom_ref);
		$readmemh("source/fc_weights.hex", fc_rom_ref);
		for (int oy = 0; oy < `LENET_CONV_MAP; oy++) begin
			for (int ox = 0; ox < `LENET_CONV_MAP; ox++) begin
				acc0 = 0;
				acc1 = 0;
				for (int ky = 0; ky < `LENET_CONV_K; ky++) begin
					for (int kx = 0; kx < `LENET_CONV_K; kx++) begin
						pix  = img[(oy + ky) * `LENET_IMG_SIZE + ox + kx];
						tap  = ky * `LENET_CONV_K + kx;
						acc0 += pix * signed_byte(conv_rom_ref[tap][7:0]);
						acc1 += pix * signed_byte(conv_rom_ref[tap][15:8]);
					end
				end
				conv0[oy * `LENET_CONV_MAP + ox] = saturate_feature(acc0 >>> `LENET_WEIGHT_SHIFT);
				conv1[oy * `LENET_CONV_MAP + ox] = saturate_feature(acc1 >>> `LENET_WEIGHT_SHIFT);
			end
		end
		// 2x2 max with stride 2, then relu
		for (int py = 0; py < `LENET_POOL_MAP; py++) begin
			for (int px = 0; px < `LENET_POOL_MAP; px++) begin
				base = 2 * py * `LENET_CONV_MAP + 2 * px;
				m0 = conv0[base];
				m1 = conv1[base];
				for (int dy = 0; dy < 2; dy++) begin
					for (int dx = 0; dx < 2; dx++) begin
						if (conv0[base + dy * `LENET_CONV_MAP + dx] > m0)
							m0 = conv0[base + dy * `LENET_CONV_MAP + dx];
						if (conv1[base + dy * `LENET_CONV_MAP + dx] > m1)
							m1 = conv1[base + dy * `LENET_CONV_MAP + dx];
					end
				end
				pool0[py * `LENET_POOL_MAP + px] = (m0 < 0) ? 0 : m0;
				pool1[py * `LENET_POOL_MAP + px] = (m1 < 0) ? 0 : m1;
			end
		end
		for (int c = 0; c < `LENET_CLASSES; c++) begin
			score[c] = 0;
			for (int p = 0; p < POOL_WORDS; p++) begin
				score[c] += pool0[p] * signed_byte(fc_rom_ref[p][159 - c * 8 -: 8]);
				score[c] += pool1[p] * signed_byte(fc_rom_ref[p][79 - c * 8 -: 8]);
			end
		end
		// lowest index wins a tie
		best = 0;
		for (int c = 1; c < `LENET_CLASSES; c++) begin
			if (score[c] > score[best])
				best = c;
		end
		return digit_t'(best);
	endfunction

	task automatic check_digit(input string name, input digit_t exp, input digit_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// compares every result as it appears on the outputs
	always @(negedge clk) begin
		if (!reset_i) begin
			if (src_rd_en) begin
				reads++;
				check_flag({test_name, " read address"}, 1'b1,
					!$isunknown(src_addr) && int'(src_addr) < IMG_PIXELS);
			end
			if (ready) begin
				ready_count++;
				check_flag({test_name, " ready_o single cycle"}, 1'b0, ready_prev);
				if (exp_q.size() == 0) begin
					errors++;
					$display("ready_o pulsed in %s with no image outstanding", test_name);
				end else begin
					exp_digit = exp_q.pop_front();
					check_digit({test_name, " digit"}, exp_digit, digit);
				end
				check_count({test_name, " reads"}, READS_PER_IMAGE, reads);
				reads = 0;
			end
			ready_prev = ready;
		end
	end

	task automatic load_random_image();
		for (int i = 0; i < IMG_PIXELS; i++)
			img[i] = next_random();
	endtask

	task automatic start_image(input digit_t exp);
		if (!aborted) begin
			exp_q.push_back(exp);
			@(negedge clk);
			go_i = 1'b1;
			@(negedge clk);
			go_i = 1'b0;
		end
	endtask

	task automatic wait_ready(input int target);
		int cycles;
		cycles = 0;
		while (!aborted && ready_count < target && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!aborted && ready_count < target) begin
			errors++;
			aborted = 1'b1;
			$display("%s: ready_o did not arrive within %0d cycles", test_name, TIMEOUT);
		end
	endtask

	initial begin
		reset_i = 1'b1;
		go_i    = 1'b0;
		for (int i = 0; i < IMG_PIXELS; i++)
			img[i] = '0;
		repeat (3) @(negedge clk);
		reset_i = 1'b0;

		check_flag("reset src_rd_en_o", 1'b0, src_rd_en);
		check_flag("reset ready_o", 1'b0, ready);
		check_digit("reset digit_o", '0, digit);

		test_name = "single image";
		load_random_image();
		start_image(expected_digit());
		wait_ready(1);

		test_name = "back to back";
		for (int n = 0; n < 8; n++) begin
			load_random_image();
			start_image(expected_digit());
			wait_ready(2 + n);
		end

		// all scores are zero, so class 0 wins
		test_name = "zero image";
		for (int i = 0; i < IMG_PIXELS; i++)
			img[i] = '0;
		start_image('0);
		wait_ready(10);

		// a second go while busy must be ignored
		test_name = "go mid image";
		load_random_image();
		start_image(expected_digit());
		repeat (100) @(negedge clk);
		go_i = 1'b1;
		@(negedge clk);
		go_i = 1'b0;
		wait_ready(11);
		repeat (400) @(negedge clk);
		if (!aborted)
			check_count("ready_o pulses after mid image go", 11, ready_count);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !aborted)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
